/* flist.f */
+incdir+logic
logic/axi_chan_pkg.sv
logic/mem_bank_pkg.sv
logic/beat_sched.sv
logic/bank_split.sv
logic/resp_route.sv
logic/axi_mem_bridge.sv
tb/bank_mem_model.sv
tb/tb_axi_mem_bridge.sv

/* logic/axi_chan_pkg.sv */
/*
  AXI channel payloads as seen on the slave port.
  INCR bursts of full-width beats only, so no size, burst,
  resp or user fields exist.
*/
`include "bridge_defs.svh"

package axi_chan_pkg;

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [`AXI_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI_LEN_W-1:0]  axi_len_t;

  // Shared by AR and AW
  typedef struct packed {
    axi_addr_t addr;
    axi_id_t   id;
    axi_len_t  len;
  } ax_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } w_chan_t;

  // Response is always OKAY
  typedef struct packed {
    axi_data_t data;
    axi_id_t   id;
    logic      last;
  } r_chan_t;

  typedef struct packed {
    axi_id_t id;
  } b_chan_t;

endpackage

/* logic/axi_mem_bridge.sv */
/*
  AXI-style slave to banked memory bridge, INCR bursts only.
  Every bank request must get exactly one rvalid, in order.
  All responses are OKAY; read/write ordering is left to software.
*/
`include "bridge_defs.svh"

module axi_mem_bridge (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     ar_valid_i,
  input  axi_chan_pkg::ax_chan_t                   ar_i,
  output logic                                     ar_ready_o,
  input  logic                                     aw_valid_i,
  input  axi_chan_pkg::ax_chan_t                   aw_i,
  output logic                                     aw_ready_o,
  input  logic                                     w_valid_i,
  input  axi_chan_pkg::w_chan_t                    w_i,
  output logic                                     w_ready_o,
  output logic                                     r_valid_o,
  output axi_chan_pkg::r_chan_t                    r_o,
  input  logic                                     r_ready_i,
  output logic                                     b_valid_o,
  output axi_chan_pkg::b_chan_t                    b_o,
  input  logic                                     b_ready_i,
  output logic [`NUM_BANKS-1:0]                    bank_req_o,
  output mem_bank_pkg::bank_req_t [`NUM_BANKS-1:0] bank_o,
  input  logic [`NUM_BANKS-1:0]                    bank_gnt_i,
  input  logic [`NUM_BANKS-1:0]                    bank_rvalid_i,
  input  mem_bank_pkg::bank_data_t [`NUM_BANKS-1:0] bank_rdata_i,
  output logic                                     busy_o
);
  import mem_bank_pkg::*;

  logic                   beat_valid;   // Beat transfers this cycle
  mem_beat_t              beat;
  beat_meta_t             meta;
  logic                   split_ready;
  logic                   meta_room;
  logic                   inflight;
  logic                   resp_valid;
  logic                   rd_valid;
  logic                   rd_ready;
  logic [`AXI_DATA_W-1:0] rd_data;

  beat_sched beat_sched_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ar_valid_i    (ar_valid_i),
    .ar_i          (ar_i),
    .ar_ready_o    (ar_ready_o),
    .aw_valid_i    (aw_valid_i),
    .aw_i          (aw_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_i           (w_i),
    .w_ready_o     (w_ready_o),
    .beat_valid_o  (beat_valid),
    .beat_o        (beat),
    .meta_o        (meta),
    .split_ready_i (split_ready),
    .meta_room_i   (meta_room),
    .inflight_i    (inflight),
    .resp_valid_i  (resp_valid),
    .busy_o        (busy_o)
  );

  bank_split bank_split_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .beat_valid_i  (beat_valid),
    .beat_i        (beat),
    .split_ready_o (split_ready),
    .bank_req_o    (bank_req_o),
    .bank_o        (bank_o),
    .bank_gnt_i    (bank_gnt_i),
    .bank_rvalid_i (bank_rvalid_i),
    .bank_rdata_i  (bank_rdata_i),
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data),
    .rd_ready_i    (rd_ready)
  );

  resp_route resp_route_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_push_i  (beat_valid),
    .meta_i       (meta),
    .meta_room_o  (meta_room),
    .inflight_o   (inflight),
    .rd_valid_i   (rd_valid),
    .rd_data_i    (rd_data),
    .rd_ready_o   (rd_ready),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .r_ready_i    (r_ready_i),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o),
    .b_ready_i    (b_ready_i),
    .resp_valid_o (resp_valid)
  );

endmodule

/* logic/bank_split.sv */
/*
  Fans each beat out to the banks and joins the returned slices.
  Each bank has a one-entry fall-through request register and a
  META_DEPTH-entry fall-through response buffer, so responses never
  overflow while the meta FIFO bounds the beats in flight.
*/
`include "bridge_defs.svh"

module bank_split (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      beat_valid_i,
  input  mem_bank_pkg::mem_beat_t                   beat_i,
  output logic                                      split_ready_o,
  output logic [`NUM_BANKS-1:0]                     bank_req_o,
  output mem_bank_pkg::bank_req_t [`NUM_BANKS-1:0]  bank_o,
  input  logic [`NUM_BANKS-1:0]                     bank_gnt_i,
  input  logic [`NUM_BANKS-1:0]                     bank_rvalid_i,
  input  mem_bank_pkg::bank_data_t [`NUM_BANKS-1:0] bank_rdata_i,
  output logic                                      rd_valid_o,
  output axi_chan_pkg::axi_data_t                   rd_data_o,
  input  logic                                      rd_ready_i
);
  import mem_bank_pkg::*;

  localparam int unsigned PtrW = $clog2(`META_DEPTH);
  localparam int unsigned CntW = $clog2(`META_DEPTH + 1);

  logic [`NUM_BANKS-1:0]       req_room;
  logic [`NUM_BANKS-1:0]       resp_room;
  logic [`NUM_BANKS-1:0]       resp_valid;
  bank_data_t [`NUM_BANKS-1:0] resp_data;
  logic                        rd_pop;

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank
    bank_req_t       req_in, req_q;
    logic            req_full_q;
    bank_data_t      resp_mem [`META_DEPTH];
    logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0] cnt_q;
    logic            resp_empty, resp_push, resp_pop;

    assign req_in = '{
      addr: beat_i.addr + `AXI_ADDR_W'(i * `BANK_STRB_W),
      data: beat_i.data[i*`BANK_DATA_W +: `BANK_DATA_W],
      strb: beat_i.strb[i*`BANK_STRB_W +: `BANK_STRB_W],
      we:   beat_i.we
    };

    assign req_room[i]   = ~req_full_q;
    assign bank_req_o[i] = req_full_q | beat_valid_i; // Falls through when empty
    assign bank_o[i]     = req_full_q ? req_q : req_in;

    // Response buffer, bypassed when empty
    assign resp_empty    = (cnt_q == '0);
    assign resp_valid[i] = ~resp_empty | bank_rvalid_i[i];
    assign resp_data[i]  = resp_empty ? bank_rdata_i[i] : resp_mem[rd_ptr_q];
    assign resp_room[i]  = (cnt_q != CntW'(`META_DEPTH));
    assign resp_push     = bank_rvalid_i[i] & ~(resp_empty & rd_pop);
    assign resp_pop      = rd_pop & ~resp_empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_full_q <= 1'b0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        cnt_q      <= '0;
      end else begin
        if (req_full_q) begin
          req_full_q <= ~bank_gnt_i[i];
        end else if (beat_valid_i && !bank_gnt_i[i]) begin
          req_full_q <= 1'b1;
        end
        if (resp_push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (resp_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        cnt_q <= cnt_q + CntW'(resp_push) - CntW'(resp_pop);
      end
    end

    always_ff @(posedge clk_i) begin
      if (!req_full_q && beat_valid_i) req_q <= req_in;
      if (resp_push) resp_mem[wr_ptr_q] <= bank_rdata_i[i];
    end
  end

  assign split_ready_o = (&req_room) & (&resp_room);

  // Word is complete once every bank has answered
  assign rd_valid_o = &resp_valid;
  assign rd_data_o  = resp_data;
  assign rd_pop     = rd_valid_o & rd_ready_i;

endmodule

/* logic/beat_sched.sv */
/*
  Burst tracking and read/write beat arbitration.
  AR is accepted into an idle read slot; the first beat follows a cycle later.
  AW is latched when AW and W are both valid, but only handshaken
  together with the first W beat. Low address bits are ignored.
*/
`include "bridge_defs.svh"

module beat_sched (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ar_valid_i,
  input  axi_chan_pkg::ax_chan_t   ar_i,
  output logic                     ar_ready_o,
  input  logic                     aw_valid_i,
  input  axi_chan_pkg::ax_chan_t   aw_i,
  output logic                     aw_ready_o,
  input  logic                     w_valid_i,
  input  axi_chan_pkg::w_chan_t    w_i,
  output logic                     w_ready_o,
  output logic                     beat_valid_o,
  output mem_bank_pkg::mem_beat_t  beat_o,
  output mem_bank_pkg::beat_meta_t meta_o,
  input  logic                     split_ready_i,
  input  logic                     meta_room_i,
  input  logic                     inflight_i,
  input  logic                     resp_valid_i,
  output logic                     busy_o
);
  import mem_bank_pkg::*;

  localparam int unsigned OffW = $clog2(`AXI_STRB_W);

  logic [`AXI_LEN_W:0]    r_cnt_q, w_cnt_q;   // Beats left in the burst
  logic [`AXI_ADDR_W-1:0] r_addr_q, w_addr_q;
  logic [`AXI_ID_W-1:0]   r_id_q, w_id_q;
  logic                   r_first_q, w_first_q; // No beat of the burst taken yet
  logic                   sel_q;              // 1 selects the write side
  logic                   lock_q;
  logic                   rd_valid, wr_valid;
  logic                   sel, offered;
  logic                   aw_load;
  logic                   rd_step, wr_step;
  mem_beat_t              rd_beat, wr_beat;
  beat_meta_t             rd_meta, wr_meta;

  assign rd_valid = (r_cnt_q != '0);
  assign wr_valid = (w_cnt_q != '0) & w_valid_i;

  assign ar_ready_o = ar_valid_i & (r_cnt_q == '0);
  assign aw_load    = aw_valid_i & w_valid_i & (w_cnt_q == '0);

  assign rd_beat = '{addr: r_addr_q, data: '0, strb: '0, we: 1'b0};
  assign rd_meta = '{id: r_id_q, last: (r_cnt_q == 1), write: 1'b0};
  assign wr_beat = '{addr: w_addr_q, data: w_i.data, strb: w_i.strb, we: 1'b1};
  assign wr_meta = '{id: w_id_q, last: (w_cnt_q == 1), write: 1'b1};

  always_comb begin
    sel = sel_q; // Held while locked or idle
    if (!lock_q) begin
      if (rd_valid ^ wr_valid) begin
        sel = wr_valid;
      end else if (rd_valid && wr_valid) begin
        // A burst under way wins, else round robin
        if (r_first_q != w_first_q) begin
          sel = r_first_q;
        end else begin
          sel = ~sel_q;
        end
      end
    end
  end

  assign offered      = sel ? wr_valid : rd_valid;
  assign beat_valid_o = offered & split_ready_i & meta_room_i;
  assign beat_o       = sel ? wr_beat : rd_beat;
  assign meta_o       = sel ? wr_meta : rd_meta;

  assign rd_step    = beat_valid_o & ~sel;
  assign wr_step    = beat_valid_o & sel;
  assign w_ready_o  = wr_step;
  assign aw_ready_o = wr_step & w_first_q; // AW goes with the first W

  assign busy_o = ar_valid_i | aw_valid_i | w_valid_i | resp_valid_i |
                  rd_valid | (w_cnt_q != '0) | inflight_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_cnt_q   <= '0;
      w_cnt_q   <= '0;
      r_first_q <= 1'b0;
      w_first_q <= 1'b0;
      sel_q     <= 1'b0;
      lock_q    <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= offered & ~beat_valid_o;
      if (ar_ready_o) begin
        r_cnt_q   <= {1'b0, ar_i.len} + 1'b1;
        r_first_q <= 1'b1;
      end else if (rd_step) begin
        r_cnt_q   <= r_cnt_q - 1'b1;
        r_first_q <= 1'b0;
      end
      if (aw_load) begin
        w_cnt_q   <= {1'b0, aw_i.len} + 1'b1;
        w_first_q <= 1'b1;
      end else if (wr_step) begin
        w_cnt_q   <= w_cnt_q - 1'b1;
        w_first_q <= 1'b0;
      end
    end
  end

  // Burst address and id
  always_ff @(posedge clk_i) begin
    if (ar_ready_o) begin
      r_addr_q <= {ar_i.addr[`AXI_ADDR_W-1:OffW], {OffW{1'b0}}};
      r_id_q   <= ar_i.id;
    end else if (rd_step) begin
      r_addr_q <= r_addr_q + `AXI_ADDR_W'(`AXI_STRB_W);
    end
    if (aw_load) begin
      w_addr_q <= {aw_i.addr[`AXI_ADDR_W-1:OffW], {OffW{1'b0}}};
      w_id_q   <= aw_i.id;
    end else if (wr_step) begin
      w_addr_q <= w_addr_q + `AXI_ADDR_W'(`AXI_STRB_W);
    end
  end

endmodule

/* logic/bridge_defs.svh */
/*
  Sizes shared by the AXI-to-bank bridge and its testbench.
  AXI_DATA_W must be a power of two, at least 16 bits.
  NUM_BANKS must split the data word into whole bytes per bank.
  META_DEPTH must be a power of two and at least 2.
*/
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

`define AXI_ADDR_W 16 // Byte address
`define AXI_DATA_W 32
`define AXI_ID_W   4
`define AXI_LEN_W  8  // Beats are len + 1

`define NUM_BANKS  2
`define META_DEPTH 4  // Beats in flight in the memory

// Derived sizes
`define AXI_STRB_W  (`AXI_DATA_W / 8)
`define BANK_DATA_W (`AXI_DATA_W / `NUM_BANKS)
`define BANK_STRB_W (`BANK_DATA_W / 8)

`endif

/* logic/mem_bank_pkg.sv */
/*
  Beat and bank request types on the memory side of the bridge.
  Addresses are byte addresses, word aligned by the scheduler.
*/
`include "bridge_defs.svh"

package mem_bank_pkg;

  typedef logic [`AXI_ADDR_W-1:0]  mem_addr_t;
  typedef logic [`BANK_DATA_W-1:0] bank_data_t;
  typedef logic [`BANK_STRB_W-1:0] bank_strb_t;

  // One full-width beat before the bank split
  typedef struct packed {
    mem_addr_t               addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                    we;
  } mem_beat_t;

  // Held in the response FIFO until the data returns
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic                 last;
    logic                 write;
  } beat_meta_t;

  typedef struct packed {
    mem_addr_t  addr;
    bank_data_t data;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

endpackage

/* logic/resp_route.sv */
/*
  Beat metadata FIFO and response steering.
  Read beats go to R, the last beat of a write burst to B,
  other write beats are dropped once their banks have answered.
*/
`include "bridge_defs.svh"

module resp_route (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       meta_push_i,
  input  mem_bank_pkg::beat_meta_t   meta_i,
  output logic                       meta_room_o,
  output logic                       inflight_o,
  input  logic                       rd_valid_i,
  input  axi_chan_pkg::axi_data_t    rd_data_i,
  output logic                       rd_ready_o,
  output logic                       r_valid_o,
  output axi_chan_pkg::r_chan_t      r_o,
  input  logic                       r_ready_i,
  output logic                       b_valid_o,
  output axi_chan_pkg::b_chan_t      b_o,
  input  logic                       b_ready_i,
  output logic                       resp_valid_o
);
  import mem_bank_pkg::*;

  localparam int unsigned PtrW = $clog2(`META_DEPTH);
  localparam int unsigned CntW = $clog2(`META_DEPTH + 1);

  beat_meta_t      meta_mem [`META_DEPTH];
  beat_meta_t      head;
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            join_valid, to_r, to_b, pop;

  assign meta_room_o = (cnt_q != CntW'(`META_DEPTH));
  assign inflight_o  = (cnt_q != '0);
  assign head        = meta_mem[rd_ptr_q];

  assign join_valid = rd_valid_i & inflight_o;
  assign to_r       = ~head.write;
  assign to_b       = head.write & head.last;

  assign r_valid_o    = join_valid & to_r;
  assign b_valid_o    = join_valid & to_b;
  assign resp_valid_o = r_valid_o | b_valid_o;

  assign r_o = '{data: rd_data_i, id: head.id, last: head.last};
  assign b_o = '{id: head.id};

  always_comb begin
    if (to_r) begin
      rd_ready_o = inflight_o & r_ready_i;
    end else if (to_b) begin
      rd_ready_o = inflight_o & b_ready_i;
    end else begin
      rd_ready_o = inflight_o; // Silent write beat
    end
  end

  assign pop = rd_valid_i & rd_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (meta_push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + CntW'(meta_push_i) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) meta_mem[wr_ptr_q] <= meta_i;
  end

endmodule

/* tb/bank_mem_model.sv */
/*
  Behavioral memory bank with random grant and response delays.
  A grant comes 0 to 3 cycles after a request is seen, its response
  1 to 4 cycles after the grant, in order and once per request.
  The byte array spans the whole address space and starts with a
  fill pattern that the testbench reference memory shares.
*/
`include "bridge_defs.svh"

module bank_mem_model (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  mem_bank_pkg::bank_req_t  req_data_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output mem_bank_pkg::bank_data_t rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import mem_bank_pkg::*;

  logic [7:0]  mem [0:(1 << `AXI_ADDR_W)-1];
  bank_data_t  resp_q [$];  // Data waiting to go back
  int unsigned due_q [$];   // Cycle in which each response is due
  int unsigned cycle;
  int unsigned last_due;
  logic [1:0]  wait_q;      // Cycles left before the next grant

  function automatic logic [7:0] fill_byte(input int unsigned addr);
    return 8'(addr) ^ 8'((addr >> 8) * 13) ^ 8'h3c;
  endfunction

  initial begin
    for (int a = 0; a < (1 << `AXI_ADDR_W); a++) begin
      mem[a] = fill_byte(a);
    end
    wait_q   = '0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    cycle    = 0;
    last_due = 0;
  end

  assign gnt_o = req_i & (wait_q == '0);

  always @(posedge clk_i or negedge rst_ni) begin
    bank_data_t  data;
    int unsigned due;
    mem_addr_t   a;
    if (!rst_ni) begin
      wait_q   <= '0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      cycle    = 0;
      last_due = 0;
      resp_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      rvalid_o <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        rvalid_o <= 1'b1;
        rdata_o  <= resp_q.pop_front();
        void'(due_q.pop_front());
      end
      if (req_i && gnt_o) begin
        for (int b = 0; b < `BANK_STRB_W; b++) begin
          a = req_data_i.addr + mem_addr_t'(b);
          data[8*b +: 8] = mem[a];  // Read before the write
          if (req_data_i.we && req_data_i.strb[b]) begin
            mem[a] = req_data_i.data[8*b +: 8];
          end
        end
        due = cycle + 1 + $urandom_range(3);
        if (due <= last_due) due = last_due + 1;  // Keep the order
        last_due = due;
        resp_q.push_back(data);
        due_q.push_back(due);
        wait_q <= 2'($urandom_range(3));
      end else if (req_i && wait_q != '0) begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

endmodule

/* tb/tb_axi_mem_bridge.sv */
/*
  Testbench for the AXI to banked memory bridge.
  Random INCR bursts are checked against a byte reference memory.
  Concurrent read and write streams use disjoint regions, since
  the bridge does not order reads behind writes.
*/
`include "bridge_defs.svh"

module tb_axi_mem_bridge;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_chan_pkg::*;
  import mem_bank_pkg::*;

  localparam int unsigned Seed    = 32'h0695_6339;
  localparam int          Timeout = 2000;  // Cycles allowed per wait loop
  localparam int          ClkHalf = 20;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i;
  logic ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o, busy_o;
  ax_chan_t ar_i, aw_i;
  w_chan_t  w_i;
  r_chan_t  r_o;
  b_chan_t  b_o;
  logic [`NUM_BANKS-1:0]            bank_req;
  bank_req_t [`NUM_BANKS-1:0]       bank_req_data;
  wire [`NUM_BANKS-1:0]             bank_gnt;
  wire [`NUM_BANKS-1:0]             bank_rvalid;
  wire bank_data_t [`NUM_BANKS-1:0] bank_rdata;

  logic [7:0]  ref_mem [0:(1 << `AXI_ADDR_W)-1];
  r_chan_t     exp_r [$];  // R beats in AR order
  axi_id_t     exp_b [$];  // B ids in AW order
  int          errors = 0;
  int          checks = 0;
  logic        rand_ready = 1'b0;
  axi_addr_t   addr;

  always #(ClkHalf) clk_i = ~clk_i;

  axi_mem_bridge axi_mem_bridge_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ar_valid_i    (ar_valid_i),
    .ar_i          (ar_i),
    .ar_ready_o    (ar_ready_o),
    .aw_valid_i    (aw_valid_i),
    .aw_i          (aw_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_i           (w_i),
    .w_ready_o     (w_ready_o),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .r_ready_i     (r_ready_i),
    .b_valid_o     (b_valid_o),
    .b_o           (b_o),
    .b_ready_i     (b_ready_i),
    .bank_req_o    (bank_req),
    .bank_o        (bank_req_data),
    .bank_gnt_i    (bank_gnt),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .busy_o        (busy_o)
  );

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_mem
    bank_mem_model bank_mem_model_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (bank_req[i]),
      .req_data_i (bank_req_data[i]),
      .gnt_o      (bank_gnt[i]),
      .rvalid_o   (bank_rvalid[i]),
      .rdata_o    (bank_rdata[i])
    );
  end

  function automatic logic [7:0] fill_byte(input int unsigned addr);
    return 8'(addr) ^ 8'((addr >> 8) * 13) ^ 8'h3c;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("Timeout at %0d ns: %s", $time, what);
    finish_run();
  endtask

  // AW goes up with the first W beat; ref_mem follows the strobes
  task automatic write_burst(input axi_addr_t start, input axi_id_t id,
                             input int unsigned len);
    axi_addr_t base;
    axi_addr_t a;
    w_chan_t   w;
    int        cycles;
    base = start & ~axi_addr_t'(`AXI_STRB_W - 1);
    @(negedge clk_i);
    exp_b.push_back(id);
    aw_i       = '{addr: start, id: id, len: axi_len_t'(len)};
    aw_valid_i = 1'b1;
    for (int k = 0; k <= len; k++) begin
      w.data = $urandom();
      w.strb = axi_strb_t'($urandom());
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        a = base + axi_addr_t'(k * `AXI_STRB_W + b);
        if (w.strb[b]) ref_mem[a] = w.data[8*b +: 8];
      end
      w_i       = w;
      w_valid_i = 1'b1;
      cycles    = 0;
      do begin
        @(posedge clk_i);
        cycles++;
        if (cycles > Timeout) fail_timeout("W beat was never accepted");
      end while (!w_ready_o);
      if (k == 0) check_value("aw_ready_o", aw_ready_o, 1'b1);
      @(negedge clk_i);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      repeat ($urandom_range(2)) @(negedge clk_i);
    end
  endtask

  task automatic read_burst(input axi_addr_t start, input axi_id_t id,
                            input int unsigned len);
    axi_addr_t base;
    axi_addr_t a;
    r_chan_t   beat;
    int        cycles;
    base = start & ~axi_addr_t'(`AXI_STRB_W - 1);
    @(negedge clk_i);
    for (int k = 0; k <= len; k++) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        a = base + axi_addr_t'(k * `AXI_STRB_W + b);
        beat.data[8*b +: 8] = ref_mem[a];
      end
      beat.id   = id;
      beat.last = (k == len);
      exp_r.push_back(beat);
    end
    ar_i       = '{addr: start, id: id, len: axi_len_t'(len)};
    ar_valid_i = 1'b1;
    cycles     = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) fail_timeout("AR was never accepted");
    end while (!ar_ready_o);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    repeat ($urandom_range(3)) @(negedge clk_i);
  endtask

  // Returns on a falling edge once everything has been answered
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (exp_r.size() != 0 || exp_b.size() != 0 || busy_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        if (exp_r.size() != 0 || exp_b.size() != 0) begin
          fail_timeout("expected R or B responses never arrived");
        end else begin
          fail_timeout("busy_o stayed high after all responses");
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rand_ready) begin
      r_ready_i = ($urandom_range(3) != 0);
      b_ready_i = ($urandom_range(1) != 0);
    end else begin
      r_ready_i = 1'b1;
      b_ready_i = 1'b1;
    end
  end

  // Scoreboard
  always @(posedge clk_i) begin
    r_chan_t exp;
    if (rst_ni) begin
      if (exp_r.size() != 0 || exp_b.size() != 0) check_value("busy_o", busy_o, 1'b1);
      if (r_valid_o && r_ready_i) begin
        if (exp_r.size() == 0) begin
          errors++;
          $display("R beat with id %h arrived at %0d ns with no read outstanding",
                   r_o.id, $time);
        end else begin
          exp = exp_r.pop_front();
          check_value("r_o.data", r_o.data, exp.data);
          check_value("r_o.id", r_o.id, exp.id);
          check_value("r_o.last", r_o.last, exp.last);
        end
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_b.size() == 0) begin
          errors++;
          $display("B with id %h arrived at %0d ns with no write outstanding", b_o.id, $time);
        end else begin
          check_value("b_o.id", b_o.id, exp_b.pop_front());
        end
      end
    end
  end

  initial begin
    void'($urandom(Seed));
    rst_ni     = 1'b0;
    ar_valid_i = 1'b0;
    ar_i       = '0;
    aw_valid_i = 1'b0;
    aw_i       = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    for (int a = 0; a < (1 << `AXI_ADDR_W); a++) begin
      ref_mem[a] = fill_byte(a);
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("ar_ready_o", ar_ready_o, 1'b0);
    check_value("aw_ready_o", aw_ready_o, 1'b0);
    check_value("w_ready_o", w_ready_o, 1'b0);
    check_value("r_valid_o", r_valid_o, 1'b0);
    check_value("b_valid_o", b_valid_o, 1'b0);
    check_value("bank_req_o", bank_req, '0);
    check_value("busy_o", busy_o, 1'b0);

    // Single beats, each read back after its B
    for (int n = 0; n < 16; n++) begin
      addr = 16'h1000 + axi_addr_t'($urandom_range(16'h0fff));
      write_burst(addr, axi_id_t'($urandom()), 0);
      wait_idle();
      read_burst(addr, axi_id_t'($urandom()), 0);
      wait_idle();
    end

    @(posedge clk_i);
    rand_ready = 1'b1;
    for (int n = 0; n < 12; n++) begin
      addr = 16'h2000 + axi_addr_t'($urandom_range(16'h03ff));
      write_burst(addr, axi_id_t'($urandom()), $urandom_range(7));
    end
    wait_idle();
    for (int n = 0; n < 12; n++) begin
      addr = 16'h2000 + axi_addr_t'($urandom_range(16'h03ff));
      read_burst(addr, axi_id_t'($urandom()), $urandom_range(7));
    end
    wait_idle();

    // Both streams at once, disjoint regions
    fork
      begin
        for (int n = 0; n < 24; n++) begin
          write_burst(16'h4000 + axi_addr_t'($urandom_range(16'h0fff)),
                      axi_id_t'($urandom()), $urandom_range(7));
        end
      end
      begin
        for (int n = 0; n < 24; n++) begin
          read_burst(16'h8000 + axi_addr_t'($urandom_range(16'h0fff)),
                     axi_id_t'($urandom()), $urandom_range(7));
        end
      end
    join
    wait_idle();

    @(posedge clk_i);
    rand_ready = 1'b0;
    repeat (4) @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    check_value("r_valid_o", r_valid_o, 1'b0);
    check_value("b_valid_o", b_valid_o, 1'b0);
    finish_run();
  end

endmodule
